// ==== Makefile ====
# Verilator build and run of the ARM decode stage testbench.

TOP := tb_arm_decode

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --assert -f filelist.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q "^=== PASS ===$$"

clean:
	rm -rf obj_dir

// ==== arm_decode_top.sv ====
// ====================
// ARM decode stage top. Classifier, class decoders
// and the registered select.
// ====================

`timescale 1ns/1ps

module arm_decode_top
(
        input  logic                    i_clk,
        input  logic                    i_reset,
        input  logic [31:0]             i_instr,
        input  logic                    i_valid,
        input  decode_pkg::exc_req_t    i_exc,          // IRQ, FIQ, prefetch abort.
        input  logic                    i_stall,        // Downstream busy.
        output decode_pkg::uop_t        o_uop,
        output logic                    o_valid
);

decode_pkg::instr_class_t       instr_class;
decode_pkg::uop_t               dp_uop;
decode_pkg::uop_t               ls_uop;

instr_classify u_classify
(
        .i_instr        (i_instr),
        .o_class        (instr_class)
);

dp_decode u_dp_decode
(
        .i_instr        (i_instr),
        .o_uop          (dp_uop)
);

ls_decode u_ls_decode
(
        .i_instr        (i_instr),
        .o_uop          (ls_uop)
);

decode_select u_select
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_class        (instr_class),
        .i_instr        (i_instr),
        .i_valid        (i_valid),
        .i_exc          (i_exc),
        .i_stall        (i_stall),
        .i_dp_uop       (dp_uop),
        .i_ls_uop       (ls_uop),
        .o_uop          (o_uop),
        .o_valid        (o_valid)
);

endmodule

// ==== decode_pkg.sv ====
// ====================
// ARM decode package. Register indices, opcodes, instruction
// patterns and the packed micro-operation bundle.
// ====================

package decode_pkg;

        // ====================
        // Registers and conditions.
        // ====================

        typedef logic [4:0] reg_idx_t;                  // 16 arch regs plus internal ones.

        localparam reg_idx_t ARCH_LR      = 5'd14;
        localparam reg_idx_t ARCH_PC      = 5'd15;
        localparam reg_idx_t RAZ_REGISTER = 5'd31;      // Reads as zero, writes dropped.

        localparam logic [31:0] PC_ADJUST = 32'd4;      // LR = PC - 4 on exception entry.

        typedef logic [3:0] cond_t;

        localparam cond_t AL = 4'b1110;                 // Always.
        localparam cond_t NV = 4'b1111;                 // Never. Marks an empty slot.

        // Data processing opcodes, same order as bits 24:21.
        typedef enum logic [3:0] {
                AND, EOR, SUB, RSB, ADD, ADC, SBC, RSC,
                TST, TEQ, CMP, CMN, ORR, MOV, BIC, MVN
        } alu_op_t;

        // Lower four follow bits 6:5 of the instruction.
        typedef enum logic [2:0] {
                LSL, LSR, ASR, ROR, RORI, RRC, ROR_1
        } shift_op_t;

        // ====================
        // Bundle fields.
        // ====================

        typedef struct packed {
                logic           is_immed;               // 1 = constant, 0 = register index.
                logic [31:0]    value;
        } operand_t;

        typedef struct packed {
                operand_t       source;
                operand_t       length;
                shift_op_t      op;
        } shift_ctl_t;

        typedef struct packed {
                reg_idx_t       srcdest;                // Data register of the transfer.
                logic           load;
                logic           store;
                logic           pre_index;
                logic           ubyte;
                logic           translate;              // Force user view of memory.
        } mem_ctl_t;

        typedef struct packed {
                cond_t          cond;
                alu_op_t        alu_op;
                operand_t       alu_src;
                reg_idx_t       dest;
                logic           flag_update;
                shift_ctl_t     shift;
                mem_ctl_t       mem;
                logic           und;
        } uop_t;

        typedef enum logic [2:0] {
                CLS_DP, CLS_LS, CLS_BRANCH, CLS_SWI, CLS_UND
        } instr_class_t;

        typedef enum logic [1:0] {
                FORM_IMM_ROT, FORM_IMM_SHIFT, FORM_REG_SHIFT, FORM_LS_IMM
        } shift_form_t;

        typedef struct packed {
                logic           irq;
                logic           fiq;
                logic           abt;
        } exc_req_t;

        // Empty bundle. Condition NV so nothing executes.
        localparam uop_t UOP_IDLE = '{
                cond:        NV,
                alu_op:      AND,
                alu_src:     '0,
                dest:        '0,
                flag_update: 1'b0,
                shift:       '0,
                mem:         '{srcdest: RAZ_REGISTER, load: 1'b0, store: 1'b0,
                               pre_index: 1'b0, ubyte: 1'b0, translate: 1'b0},
                und:         1'b0
        };

        // ====================
        // Instruction patterns.
        // ====================

        // Multiply, swap and halfword transfers. Bit 25 low, bits 7 and 4 high.
        localparam logic [31:0] PAT_EXT_SPACE  = 32'b????_000?_????_????_????_????_1??1_????;
        // MRS, MSR, BX, CLZ and the saturating ops. Opcode 10xx with S clear.
        localparam logic [31:0] PAT_CTRL_SPACE = 32'b????_00?1_0??0_????_????_????_????_????;
        localparam logic [31:0] PAT_DP         = 32'b????_00??_????_????_????_????_????_????;
        localparam logic [31:0] PAT_LS_IMM     = 32'b????_010?_????_????_????_????_????_????;
        localparam logic [31:0] PAT_LS_REG     = 32'b????_011?_????_????_????_????_???0_????;
        localparam logic [31:0] PAT_BRANCH     = 32'b????_1010_????_????_????_????_????_????;
        localparam logic [31:0] PAT_SWI        = 32'b????_1111_????_????_????_????_????_????;

endpackage

// ==== decode_select.sv ====
// ====================
// Decode select and output register. Exception priority,
// branch and exception bundles, stall hold.
// ====================

`timescale 1ns/1ps

module decode_select
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  decode_pkg::instr_class_t        i_class,
        input  logic [31:0]                     i_instr,
        input  logic                            i_valid,
        input  decode_pkg::exc_req_t            i_exc,
        input  logic                            i_stall,
        input  decode_pkg::uop_t                i_dp_uop,
        input  decode_pkg::uop_t                i_ls_uop,
        output decode_pkg::uop_t                o_uop,
        output logic                            o_valid
);

logic                   exc_any;        // IRQ, FIQ or abort pending.
logic                   accept;         // Something enters the register.
decode_pkg::uop_t       exc_uop;
decode_pkg::uop_t       br_uop;
decode_pkg::uop_t       uop_nxt;

assign exc_any = |i_exc;
assign accept  = !i_stall && (i_valid || exc_any);

// ====================
// LR = PC - 4. Shared by IRQ, FIQ, abort, SWI, undefined.
// ====================
always_comb
begin
        exc_uop                         = decode_pkg::UOP_IDLE;
        exc_uop.cond                    = decode_pkg::AL;
        exc_uop.alu_op                  = decode_pkg::SUB;
        exc_uop.alu_src.value           = {27'd0, decode_pkg::ARCH_PC};
        exc_uop.dest                    = decode_pkg::ARCH_LR;
        exc_uop.shift.source.is_immed   = 1'b1;
        exc_uop.shift.source.value      = decode_pkg::PC_ADJUST;
        exc_uop.shift.length.is_immed   = 1'b1;         // LSL #0.
        exc_uop.shift.op                = decode_pkg::LSL;
end

// ====================
// PC = PC + (sext(imm24) << 2).
// ====================
always_comb
begin
        br_uop                          = decode_pkg::UOP_IDLE;
        br_uop.cond                     = i_instr[31:28];
        br_uop.alu_op                   = decode_pkg::ADD;
        br_uop.alu_src.value            = {27'd0, decode_pkg::ARCH_PC};
        br_uop.dest                     = decode_pkg::ARCH_PC;
        br_uop.shift.source.is_immed    = 1'b1;
        br_uop.shift.source.value       = {{8{i_instr[23]}}, i_instr[23:0]};
        br_uop.shift.length.is_immed    = 1'b1;
        br_uop.shift.length.value       = 32'd2;        // Word offset.
        br_uop.shift.op                 = decode_pkg::LSL;
end

// Exceptions first, then the class result, else idle.
always_comb
begin
        uop_nxt = decode_pkg::UOP_IDLE;

        if (exc_any)
                uop_nxt = exc_uop;
        else if (i_valid)
        begin
                case (i_class)
                decode_pkg::CLS_DP:     uop_nxt = i_dp_uop;
                decode_pkg::CLS_LS:     uop_nxt = i_ls_uop;
                decode_pkg::CLS_BRANCH: uop_nxt = br_uop;
                decode_pkg::CLS_SWI:    uop_nxt = exc_uop;
                default:
                begin
                        uop_nxt     = exc_uop;  // Undefined instruction trap.
                        uop_nxt.und = 1'b1;
                end
                endcase
        end
end

// Output register. Holds while stalled.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_uop   <= decode_pkg::UOP_IDLE;
                o_valid <= 1'b0;
        end
        else if (!i_stall)
        begin
                o_uop   <= uop_nxt;
                o_valid <= accept;
        end
end

// Downstream relies on a frozen bundle for the whole stall.
assert property (@(posedge i_clk) disable iff (i_reset)
        i_stall |=> $stable(o_uop) && $stable(o_valid));

// LS decode and the exception forms must never mix directions.
assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_uop.mem.load && o_uop.mem.store));

endmodule

// ==== dp_decode.sv ====
// ====================
// Data processing decode. Opcode, Rn, Rd and the
// shifter operand for all three DP formats.
// ====================

`timescale 1ns/1ps

module dp_decode
(
        input  logic [31:0]             i_instr,
        output decode_pkg::uop_t        o_uop
);

decode_pkg::shift_form_t        form;
decode_pkg::shift_ctl_t         shift;

// Operand form from I bit, bit 7 and bit 4.
always_comb
begin
        casez ({i_instr[25], i_instr[7], i_instr[4]})
        3'b1??:  form = decode_pkg::FORM_IMM_ROT;
        3'b??0:  form = decode_pkg::FORM_IMM_SHIFT;
        default: form = decode_pkg::FORM_REG_SHIFT;     // 001. 011 never classed DP.
        endcase
end

shift_operand_decode u_shift
(
        .i_instr        (i_instr),
        .i_form         (form),
        .o_shift        (shift)
);

always_comb
begin
        o_uop                   = decode_pkg::UOP_IDLE;

        o_uop.cond              = i_instr[31:28];
        o_uop.alu_op            = decode_pkg::alu_op_t'(i_instr[24:21]);
        o_uop.flag_update       = i_instr[20];                  // S bit.
        o_uop.alu_src.is_immed  = 1'b0;
        o_uop.alu_src.value     = {28'd0, i_instr[19:16]};      // Rn.
        o_uop.dest              = {1'b0, i_instr[15:12]};       // Rd.
        o_uop.shift             = shift;

        // Compares and tests only set flags.
        if (o_uop.alu_op inside {decode_pkg::TST, decode_pkg::TEQ,
                                 decode_pkg::CMP, decode_pkg::CMN})
                o_uop.dest = decode_pkg::RAZ_REGISTER;
end

endmodule

// ==== filelist.f ====
decode_pkg.sv
instr_classify.sv
shift_operand_decode.sv
dp_decode.sv
ls_decode.sv
decode_select.sv
arm_decode_top.sv
tb_arm_decode.sv

// ==== instr_classify.sv ====
// ====================
// Instruction classifier. Wildcard match of the
// instruction word against the supported formats.
// ====================

`timescale 1ns/1ps

module instr_classify
(
        input  logic [31:0]                     i_instr,
        output decode_pkg::instr_class_t        o_class
);

always_comb
begin
        // First match wins. Unsupported spaces go ahead of the DP pattern.
        casez (i_instr)
        decode_pkg::PAT_EXT_SPACE,
        decode_pkg::PAT_CTRL_SPACE:
                o_class = decode_pkg::CLS_UND;          // Dropped instruction groups.
        decode_pkg::PAT_DP:
                o_class = decode_pkg::CLS_DP;           // All three DP forms.
        decode_pkg::PAT_LS_IMM,
        decode_pkg::PAT_LS_REG:
                o_class = decode_pkg::CLS_LS;           // Word/byte transfers.
        decode_pkg::PAT_BRANCH:
                o_class = decode_pkg::CLS_BRANCH;       // B only, BL is not taken here.
        decode_pkg::PAT_SWI:
                o_class = decode_pkg::CLS_SWI;
        default:
                o_class = decode_pkg::CLS_UND;          // Media space, coprocessor, rest.
        endcase
end

endmodule

// ==== ls_decode.sv ====
// ====================
// Load/store decode. Word and byte transfers with
// immediate or shifted register offset.
// ====================

`timescale 1ns/1ps

module ls_decode
(
        input  logic [31:0]             i_instr,
        output decode_pkg::uop_t        o_uop
);

decode_pkg::shift_form_t        form;
decode_pkg::shift_ctl_t         shift;
logic                           pre_index;              // P bit.
logic                           writeback;              // W bit.

assign pre_index = i_instr[24];
assign writeback = i_instr[21];

// I bit set means a shifted register offset.
assign form = i_instr[25] ? decode_pkg::FORM_IMM_SHIFT : decode_pkg::FORM_LS_IMM;

shift_operand_decode u_shift
(
        .i_instr        (i_instr),
        .i_form         (form),
        .o_shift        (shift)
);

always_comb
begin
        o_uop                   = decode_pkg::UOP_IDLE;

        o_uop.cond              = i_instr[31:28];
        o_uop.alu_op            = i_instr[23] ? decode_pkg::ADD   // Offset up.
                                              : decode_pkg::SUB;  // Offset down.
        o_uop.alu_src.is_immed  = 1'b0;
        o_uop.alu_src.value     = {28'd0, i_instr[19:16]};      // Base Rn.
        o_uop.shift             = shift;

        // ====================
        // Memory side.
        // ====================
        o_uop.mem.srcdest       = {1'b0, i_instr[15:12]};       // Rd.
        o_uop.mem.load          = i_instr[20];
        o_uop.mem.store         = !i_instr[20];
        o_uop.mem.pre_index     = pre_index;
        o_uop.mem.ubyte         = i_instr[22];

        // Base update on post-index or pre-index with writeback.
        if (writeback || !pre_index)
                o_uop.dest = {1'b0, i_instr[19:16]};
        else
                o_uop.dest = decode_pkg::RAZ_REGISTER;

        // Post-index always writes back. W then requests user translation.
        o_uop.mem.translate     = !pre_index && writeback;
end

endmodule

// ==== shift_operand_decode.sv ====
// ====================
// Shifter operand decode. Source, length and type for
// the rotated immediate, shifted register and LS offset forms.
// ====================

`timescale 1ns/1ps

module shift_operand_decode
(
        input  logic [31:0]                     i_instr,
        input  decode_pkg::shift_form_t         i_form,
        output decode_pkg::shift_ctl_t          o_shift
);

always_comb
begin
        o_shift = '0;

        case (i_form)

        // ====================
        // imm8 rotated right by twice rot.
        // ====================
        decode_pkg::FORM_IMM_ROT:
        begin
                o_shift.source.is_immed = 1'b1;
                o_shift.source.value    = {24'd0, i_instr[7:0]};
                o_shift.length.is_immed = 1'b1;
                o_shift.length.value    = {27'd0, i_instr[11:8], 1'b0};   // 2 * rot.
                o_shift.op              = decode_pkg::RORI;
        end

        // ====================
        // Rm shifted by a 5-bit constant.
        // ====================
        decode_pkg::FORM_IMM_SHIFT:
        begin
                o_shift.source.is_immed = 1'b0;
                o_shift.source.value    = {28'd0, i_instr[3:0]};          // Rm.
                o_shift.length.is_immed = 1'b1;
                o_shift.length.value    = {27'd0, i_instr[11:7]};
                o_shift.op              = decode_pkg::shift_op_t'({1'b0, i_instr[6:5]});

                // Encodings of zero that mean something else.
                case (o_shift.op)
                decode_pkg::LSR,
                decode_pkg::ASR:
                begin
                        if (i_instr[11:7] == 5'd0)
                                o_shift.length.value = 32'd32;  // #0 means #32.
                end
                decode_pkg::ROR:
                begin
                        if (i_instr[11:7] == 5'd0)
                                o_shift.op = decode_pkg::RRC;   // Rotate through carry.
                        else
                                o_shift.op = decode_pkg::ROR_1; // Carry differs from RORI.
                end
                default:
                        ;                                       // LSL #0 is a plain move.
                endcase
        end

        // Rm shifted by the low byte of Rs.
        decode_pkg::FORM_REG_SHIFT:
        begin
                o_shift.source.is_immed = 1'b0;
                o_shift.source.value    = {28'd0, i_instr[3:0]};          // Rm.
                o_shift.length.is_immed = 1'b0;
                o_shift.length.value    = {28'd0, i_instr[11:8]};         // Rs.
                o_shift.op              = decode_pkg::shift_op_t'({1'b0, i_instr[6:5]});
        end

        // 12-bit load/store offset, passed through unshifted.
        default:
        begin
                o_shift.source.is_immed = 1'b1;
                o_shift.source.value    = {20'd0, i_instr[11:0]};
                o_shift.length.is_immed = 1'b1;
                o_shift.length.value    = 32'd0;
                o_shift.op              = decode_pkg::LSL;
        end
        endcase
end

endmodule

// ==== tb_arm_decode.sv ====
// ====================
// ARM decode stage testbench. Table of instructions
// with expected bundles, one table entry per cycle.
// ====================

`timescale 1ns/1ps

module tb_arm_decode;

typedef struct packed {
        logic [31:0]            instr;
        logic                   valid;
        decode_pkg::exc_req_t   exc;
        logic                   stall;
        decode_pkg::uop_t       exp_uop;
        logic                   exp_valid;
} entry_t;

logic                   clk = 1'b0;
logic                   reset;
logic [31:0]            instr;
logic                   valid;
decode_pkg::exc_req_t   exc;
logic                   stall;
decode_pkg::uop_t       uop;
logic                   uop_valid;

entry_t                 tests[$];
int                     errors = 0;
int                     cycles = 0;

always #50 clk = ~clk;                          // 100 ns period.

arm_decode_top i_dut
(
        .i_clk          (clk),
        .i_reset        (reset),
        .i_instr        (instr),
        .i_valid        (valid),
        .i_exc          (exc),
        .i_stall        (stall),
        .o_uop          (uop),
        .o_valid        (uop_valid)
);

// ====================
// Expected bundles.
// ====================

// Empty slot. Everything zero, NV, srcdest reads as zero.
function automatic decode_pkg::uop_t idle_uop();
        decode_pkg::uop_t u;
        u             = '0;
        u.cond        = decode_pkg::NV;
        u.mem.srcdest = decode_pkg::RAZ_REGISTER;
        return u;
endfunction

function automatic decode_pkg::shift_ctl_t shifter(input logic src_imm, input logic [31:0] src,
                input logic len_imm, input logic [31:0] len, input decode_pkg::shift_op_t op);
        decode_pkg::shift_ctl_t s;
        s.source.is_immed = src_imm;
        s.source.value    = src;
        s.length.is_immed = len_imm;
        s.length.value    = len;
        s.op              = op;
        return s;
endfunction

function automatic decode_pkg::uop_t dp_exp(input decode_pkg::cond_t cond,
                input decode_pkg::alu_op_t op, input logic s, input decode_pkg::reg_idx_t rn,
                input decode_pkg::reg_idx_t rd, input decode_pkg::shift_ctl_t sh);
        decode_pkg::uop_t u;
        u                  = idle_uop();
        u.cond             = cond;
        u.alu_op           = op;
        u.flag_update      = s;
        u.alu_src.is_immed = 1'b0;
        u.alu_src.value    = {27'd0, rn};       // Rn index.
        u.dest             = rd;
        u.shift            = sh;
        return u;
endfunction

function automatic decode_pkg::uop_t ls_exp(input logic up, input decode_pkg::reg_idx_t rn,
                input decode_pkg::reg_idx_t rd, input decode_pkg::reg_idx_t dest,
                input logic load, input logic pre, input logic ubyte, input logic translate,
                input decode_pkg::shift_ctl_t sh);
        decode_pkg::uop_t u;
        u                   = idle_uop();
        u.cond              = decode_pkg::AL;
        u.alu_op            = up ? decode_pkg::ADD : decode_pkg::SUB;
        u.alu_src.value     = {27'd0, rn};      // Base register.
        u.dest              = dest;
        u.shift             = sh;
        u.mem.srcdest       = rd;
        u.mem.load          = load;
        u.mem.store         = !load;
        u.mem.pre_index     = pre;
        u.mem.ubyte         = ubyte;
        u.mem.translate     = translate;
        return u;
endfunction

// PC = PC + (offset << 2).
function automatic decode_pkg::uop_t branch_exp(input decode_pkg::cond_t cond,
                input logic [31:0] offset);
        decode_pkg::uop_t u;
        u               = idle_uop();
        u.cond          = cond;
        u.alu_op        = decode_pkg::ADD;
        u.alu_src.value = {27'd0, decode_pkg::ARCH_PC};
        u.dest          = decode_pkg::ARCH_PC;
        u.shift         = shifter(1'b1, offset, 1'b1, 32'd2, decode_pkg::LSL);
        return u;
endfunction

// LR = PC - 4, always executed.
function automatic decode_pkg::uop_t exc_exp(input logic und);
        decode_pkg::uop_t u;
        u               = idle_uop();
        u.cond          = decode_pkg::AL;
        u.alu_op        = decode_pkg::SUB;
        u.alu_src.value = {27'd0, decode_pkg::ARCH_PC};
        u.dest          = decode_pkg::ARCH_LR;
        u.shift         = shifter(1'b1, 32'd4, 1'b1, 32'd0, decode_pkg::LSL);
        u.und           = und;
        return u;
endfunction

// ====================
// Table and checks.
// ====================

task automatic add_test(input logic [31:0] in, input logic vld, input decode_pkg::exc_req_t ex,
                input logic stl, input decode_pkg::uop_t exp_u, input logic exp_v);
        entry_t e;
        e.instr     = in;
        e.valid     = vld;
        e.exc       = ex;
        e.stall     = stl;
        e.exp_uop   = exp_u;
        e.exp_valid = exp_v;
        tests.push_back(e);
endtask

task automatic build_tests();
        decode_pkg::uop_t mov_lsr;
        decode_pkg::uop_t ldr_pre;
        mov_lsr = dp_exp(4'hE, decode_pkg::MOV, 1'b0, 5'd0, 5'd3,
                         shifter(1'b0, 32'd4, 1'b1, 32'd32, decode_pkg::LSR));
        ldr_pre = ls_exp(1'b1, 5'd2, 5'd1, decode_pkg::RAZ_REGISTER, 1'b1, 1'b1, 1'b0, 1'b0,
                         shifter(1'b1, 32'd8, 1'b1, 32'd0, decode_pkg::LSL));

        add_test(32'hE28214FF, 1'b0, 3'b000, 1'b0, idle_uop(), 1'b0);   // Idle cycle.
        add_test(32'hE28214FF, 1'b1, 3'b000, 1'b0,                      // ADD r1,r2,#FF ror 8.
                 dp_exp(4'hE, decode_pkg::ADD, 1'b0, 5'd2, 5'd1,
                        shifter(1'b1, 32'hFF, 1'b1, 32'd8, decode_pkg::RORI)), 1'b1);
        add_test(32'hE1A03024, 1'b1, 3'b000, 1'b0, mov_lsr, 1'b1);      // LSR #0 is #32.
        add_test(32'hE1A05066, 1'b1, 3'b000, 1'b0,                      // ROR #0 is RRX.
                 dp_exp(4'hE, decode_pkg::MOV, 1'b0, 5'd0, 5'd5,
                        shifter(1'b0, 32'd6, 1'b1, 32'd0, decode_pkg::RRC)), 1'b1);
        add_test(32'hE1A052E6, 1'b1, 3'b000, 1'b0,
                 dp_exp(4'hE, decode_pkg::MOV, 1'b0, 5'd0, 5'd5,
                        shifter(1'b0, 32'd6, 1'b1, 32'd5, decode_pkg::ROR_1)), 1'b1);
        add_test(32'hE0821413, 1'b1, 3'b000, 1'b0,                      // LSL by Rs = r4.
                 dp_exp(4'hE, decode_pkg::ADD, 1'b0, 5'd2, 5'd1,
                        shifter(1'b0, 32'd3, 1'b0, 32'd4, decode_pkg::LSL)), 1'b1);
        add_test(32'hE3570001, 1'b1, 3'b000, 1'b0,                      // CMP r7,#1.
                 dp_exp(4'hE, decode_pkg::CMP, 1'b1, 5'd7, decode_pkg::RAZ_REGISTER,
                        shifter(1'b1, 32'd1, 1'b1, 32'd0, decode_pkg::RORI)), 1'b1);
        add_test(32'hE5921008, 1'b1, 3'b000, 1'b0, ldr_pre, 1'b1);      // LDR r1,[r2,#8].
        add_test(32'hE4A43004, 1'b1, 3'b000, 1'b0,                      // STRT r3,[r4],#4.
                 ls_exp(1'b1, 5'd4, 5'd3, 5'd4, 1'b0, 1'b0, 1'b0, 1'b1,
                        shifter(1'b1, 32'd4, 1'b1, 32'd0, decode_pkg::LSL)), 1'b1);
        add_test(32'hE5D65001, 1'b1, 3'b000, 1'b0,                      // LDRB r5,[r6,#1].
                 ls_exp(1'b1, 5'd6, 5'd5, decode_pkg::RAZ_REGISTER, 1'b1, 1'b1, 1'b1, 1'b0,
                        shifter(1'b1, 32'd1, 1'b1, 32'd0, decode_pkg::LSL)), 1'b1);
        add_test(32'hE7110102, 1'b1, 3'b000, 1'b0,                      // LDR r0,[r1,-r2,LSL #2].
                 ls_exp(1'b0, 5'd1, 5'd0, decode_pkg::RAZ_REGISTER, 1'b1, 1'b1, 1'b0, 1'b0,
                        shifter(1'b0, 32'd2, 1'b1, 32'd2, decode_pkg::LSL)), 1'b1);
        add_test(32'h0A000010, 1'b1, 3'b000, 1'b0, branch_exp(4'h0, 32'h10), 1'b1);
        add_test(32'h1AFFFFFD, 1'b1, 3'b000, 1'b0, branch_exp(4'h1, 32'hFFFFFFFD), 1'b1);
        add_test(32'hE28214FF, 1'b1, 3'b100, 1'b0, exc_exp(1'b0), 1'b1); // IRQ beats DP.
        add_test(32'hEF000012, 1'b1, 3'b000, 1'b0, exc_exp(1'b0), 1'b1); // SWI.
        add_test(32'hE0000291, 1'b1, 3'b000, 1'b0, exc_exp(1'b1), 1'b1); // MUL is undefined.

        // Stall holds the MOV for three cycles.
        add_test(32'hE1A03024, 1'b1, 3'b000, 1'b0, mov_lsr, 1'b1);
        add_test(32'hE3570001, 1'b1, 3'b000, 1'b1, mov_lsr, 1'b1);
        add_test(32'h0A000010, 1'b1, 3'b000, 1'b1, mov_lsr, 1'b1);
        add_test(32'hE4A43004, 1'b1, 3'b000, 1'b1, mov_lsr, 1'b1);
        add_test(32'hE5921008, 1'b1, 3'b000, 1'b0, ldr_pre, 1'b1);      // Released.
        add_test(32'hE5921008, 1'b0, 3'b000, 1'b0, idle_uop(), 1'b0);
endtask

task automatic check_uop(input int idx, input decode_pkg::uop_t got,
                input decode_pkg::uop_t exp);
        if (got !== exp)
        begin
                errors++;
                $display("ERR %0t ns: test %0d uop got %h expected %h",
                         $time, idx, got, exp);
        end
endtask

task automatic check_valid(input int idx, input logic got, input logic exp);
        if (got !== exp)
        begin
                errors++;
                $display("ERR %0t ns: test %0d valid got %b expected %b",
                         $time, idx, got, exp);
        end
endtask

// Reset, one cycle per entry, plus margin.
always @(posedge clk)
begin
        cycles <= cycles + 1;
        if (cycles >= 16 + 2 * tests.size() + 20)
        begin
                $display("Timeout after %0d cycles, the test loop did not finish", cycles);
                $display("=== FAIL ===");
                $finish;
        end
end

// ====================
// Main sequence.
// ====================
initial
begin
        reset = 1'b1;
        instr = 32'd0;
        valid = 1'b0;
        exc   = 3'b000;
        stall = 1'b0;
        build_tests();

        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        check_valid(-1, uop_valid, 1'b0);               // Reset state.
        check_uop(-1, uop, idle_uop());

        for (int i = 0; i < tests.size(); i++)
        begin
                instr = tests[i].instr;                 // 1 ns after the edge.
                valid = tests[i].valid;
                exc   = tests[i].exc;
                stall = tests[i].stall;
                @(posedge clk);
                #1;
                check_valid(i, uop_valid, tests[i].exp_valid);
                check_uop(i, uop, tests[i].exp_uop);
        end

        valid = 1'b0;
        $display("Decode tests: %0d entries, %0d errors", tests.size(), errors);
        if (errors == 0)
                $display("=== PASS ===");
        else
                $display("=== FAIL ===");
        $finish;
end

endmodule
